// ==== dv/tb_axi_frame_writer.sv ====
/*
 * Testbench for the AXI frame write master. Runs a fixed list of jobs
 * against a random-stall source and memory slave, with error injection
 * on chosen bursts, and checks AW, W and done/err against a reference
 * model built from the burst rules. Run through run.sh.
 */

`timescale 1ns/10ps
`include "axi_wr_config.svh"

module tb_axi_frame_writer;

    // ----------------------------------------
    // Job list
    // ----------------------------------------
    localparam int NJOBS      = 9;
    localparam int INJ_NONE   = 0;
    localparam int INJ_SLVERR = 1;
    localparam int INJ_BAD_ID = 2;

    localparam int          JOB_COLS [NJOBS] = '{2, 3, 1, 2, 3, 0, 2, 4, 1};
    localparam int          JOB_ROWS [NJOBS] = '{3, 5, 5, 2, 3, 7, 1, 8, 1};
    localparam logic [31:0] JOB_BASE [NJOBS] = '{32'h1000_0000, 32'h1000_2000,
        32'h2000_0000, 32'h2000_1000, 32'h2000_2000, 32'h2800_0000,
        32'h3000_0000, 32'h4000_0000, 32'h4000_4000};
    localparam int          JOB_ERR  [NJOBS] = '{0, 0, 1, 0, 2, 0, 0, 0, 0};
    // Long job with wready held low for a while
    localparam int          JOB_HOLD [NJOBS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};

    logic                 clk;
    logic                 rst_n;
    logic                 job_valid;
    logic                 job_ready;
    axi_wr_pkg::addr_t    job_base;
    axi_wr_pkg::blk_cnt_t job_cols;
    axi_wr_pkg::blk_cnt_t job_rows;
    logic                 src_valid = 1'b0;
    logic                 src_ready;
    axi_wr_pkg::data_t    src_data = '0;
    axi_wr_pkg::axid_t    awid;
    axi_wr_pkg::addr_t    awaddr;
    axi_wr_pkg::len_t     awlen;
    logic                 awvalid;
    logic                 awready = 1'b0;
    axi_wr_pkg::data_t    wdata;
    axi_wr_pkg::strb_t    wstrb;
    logic                 wlast;
    logic                 wvalid;
    logic                 wready = 1'b0;
    logic                 bvalid = 1'b0;
    axi_wr_pkg::axid_t    bid = '0;
    logic [1:0]           bresp = 2'b00;
    logic                 bready;
    logic                 done;
    logic                 err;

    // Reference queues filled per job and drained by the compare process
    axi_wr_pkg::addr_t exp_aw_addr [$];
    axi_wr_pkg::len_t  exp_aw_len  [$];
    axi_wr_pkg::axid_t exp_aw_id   [$];
    axi_wr_pkg::data_t exp_w_data  [$];
    logic              exp_w_last  [$];
    logic              exp_err     [$];
    axi_wr_pkg::axid_t ref_id = '0;
    int                ref_src = 0;
    int                ref_bursts = 0;

    // Slave model state
    axi_wr_pkg::axid_t slv_aw_id [$];
    axi_wr_pkg::axid_t slv_b_id  [$];
    logic [31:0]       lfsr_state = 32'hd237;
    int                src_idx = 0;
    int                resp_idx = 0;
    int                inj_mode = 0;
    int                inj_burst = -1;
    logic              hold_w = 1'b0;

    int   checks = 0;
    int   errors = 0;
    int   done_cnt = 0;
    int   aw_issued = 0;
    int   w_bursts = 0;
    int   b_taken = 0;
    int   cycle_cnt = 0;
    logic job_open = 1'b0;
    logic aw_due = 1'b0;
    logic done_due = 1'b0;

    axi_frame_writer i_axi_frame_writer (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // Random stream
    // ----------------------------------------
    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Each source beat comes from its own LFSR run seeded by the beat index
    function automatic axi_wr_pkg::data_t src_word(input int idx);
        logic [31:0]       s;
        axi_wr_pkg::data_t w;
        s = 32'hd237 ^ idx;
        w = '0;
        for (int i = 0; i < `AXW_DATA_W; i++)
        begin
            s = lfsr_step(s);
            w = {w[`AXW_DATA_W-2:0], s[0]};
        end
        return w;
    endfunction

    function automatic int total_job_beats();
        int sum;
        sum = 0;
        for (int j = 0; j < NJOBS; j++)
            sum += JOB_COLS[j] * JOB_ROWS[j] * `AXW_BEATS_PER_BLK;
        return sum;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Appends one job's bursts, beats and error flag; returns the burst count
    function automatic int expect_job(input axi_wr_pkg::addr_t base, input int cols,
                                      input int rows, input int err_mode);
        int left;
        int n;
        int k;
        left = cols * rows * `AXW_BEATS_PER_BLK;
        k    = 0;
        while (left > 0)
        begin
            n = (left > `AXW_MAX_BURST) ? `AXW_MAX_BURST : left;
            exp_aw_addr.push_back(base + axi_wr_pkg::addr_t'(k * `AXW_MAX_BURST
                                                             * (`AXW_DATA_W / 8)));
            exp_aw_len.push_back(axi_wr_pkg::len_t'(n - 1));
            exp_aw_id.push_back(ref_id);
            ref_id = ref_id + axi_wr_pkg::axid_t'(1);
            for (int b = 0; b < n; b++)
            begin
                exp_w_data.push_back(src_word(ref_src));
                exp_w_last.push_back(b == n - 1);
                ref_src++;
            end
            left -= n;
            k++;
        end
        ref_bursts += k;
        exp_err.push_back((err_mode != INJ_NONE) && (k > 0));
        return k;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Source and memory slave models
    // ----------------------------------------
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (awvalid && awready)
                slv_aw_id.push_back(awid);
            awready <= (take_bits(2) != 0);

            // Queue a response once the burst completes on W
            if (wvalid && wready && wlast && (slv_aw_id.size() != 0))
                slv_b_id.push_back(slv_aw_id.pop_front());
            wready <= hold_w ? 1'b0 : (take_bits(2) != 0);

            if (src_valid && src_ready)
                src_idx++;
            if (!src_valid || src_ready)
                src_valid <= (take_bits(2) != 0);
            src_data <= src_word(src_idx);

            if (bvalid && bready)
                bvalid <= 1'b0;
            else if (!bvalid && (slv_b_id.size() != 0) && (take_bits(2) != 0))
            begin
                bvalid <= 1'b1;
                bid    <= slv_b_id[0];
                bresp  <= axi_wr_pkg::OKAY;
                if ((resp_idx == inj_burst) && (inj_mode == INJ_BAD_ID))
                    bid <= slv_b_id[0] ^ axi_wr_pkg::axid_t'(1);
                if ((resp_idx == inj_burst) && (inj_mode == INJ_SLVERR))
                    bresp <= axi_wr_pkg::SLVERR;
                void'(slv_b_id.pop_front());
                resp_idx++;
            end
        end
    end

    // ----------------------------------------
    // Compare process
    // ----------------------------------------
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (job_open)
                check_true(!job_ready, "job_ready was high while a job was open");
            if (aw_due)
                check_true(awvalid, "awvalid did not rise one cycle after the job handshake");
            aw_due = 1'b0;
            // One cycle after the final B handshake or after an empty job's accept
            check_value("done", 64'(done), 64'(done_due));
            done_due = 1'b0;

            // Responses are taken while any issued burst is still unanswered
            check_value("bready", 64'(bready), 64'(aw_issued != b_taken));
            if (bvalid && bready)
            begin
                b_taken++;
                if (b_taken == ref_bursts)
                    done_due = 1'b1;
            end

            check_true((src_valid && src_ready) == (wvalid && wready),
                       "A source beat and a W beat did not move together");

            if (awvalid && awready)
            begin
                aw_issued++;
                check_true(exp_aw_addr.size() != 0, "An AW burst came that no job called for");
                if (exp_aw_addr.size() != 0)
                begin
                    check_value("awaddr", 64'(awaddr), 64'(exp_aw_addr[0]));
                    check_value("awlen", 64'(awlen), 64'(exp_aw_len[0]));
                    check_value("awid", 64'(awid), 64'(exp_aw_id[0]));
                    void'(exp_aw_addr.pop_front());
                    void'(exp_aw_len.pop_front());
                    void'(exp_aw_id.pop_front());
                end
            end

            if (wvalid && wready)
            begin
                if (wlast)
                    w_bursts++;
                check_true(exp_w_data.size() != 0, "A W beat came beyond the expected data");
                if (exp_w_data.size() != 0)
                begin
                    check_value("wdata", 64'(wdata), 64'(exp_w_data[0]));
                    check_value("wstrb", 64'(wstrb), 64'({(`AXW_DATA_W / 8){1'b1}}));
                    check_value("wlast", 64'(wlast), 64'(exp_w_last[0]));
                    void'(exp_w_data.pop_front());
                    void'(exp_w_last.pop_front());
                end
            end
            // Queue full plus the burst held by the streamer
            check_true(aw_issued - w_bursts <= `AXW_DESC_DEPTH + 1,
                       "The address channel ran too far ahead of the data");

            if (done)
            begin
                done_cnt++;
                job_open = 1'b0;
                check_true(exp_err.size() != 0, "done pulsed while no job was open");
                if (exp_err.size() != 0)
                begin
                    check_value("err", 64'(err), 64'(exp_err[0]));
                    void'(exp_err.pop_front());
                end
                check_true((exp_aw_addr.size() == 0) && (exp_w_data.size() == 0),
                           "done came before all bursts and beats of the job were seen");
            end
            else
                check_true(!err, "err was high without done");

            if (job_valid && job_ready)
            begin
                job_open = 1'b1;
                aw_due   = (job_cols != 0) && (job_rows != 0);
                if (!aw_due)
                    done_due = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic run_job(input int j);
        int done_before;
        int first;
        int nb;
        done_before = done_cnt;
        @(negedge clk);
        hold_w   = (JOB_HOLD[j] != 0);
        first    = ref_bursts;
        nb       = expect_job(JOB_BASE[j], JOB_COLS[j], JOB_ROWS[j], JOB_ERR[j]);
        inj_mode = JOB_ERR[j];
        inj_burst = -1;
        if ((JOB_ERR[j] != INJ_NONE) && (nb > 0))
            inj_burst = first + (int'(take_bits(8)) % nb);

        @(posedge clk);
        job_valid <= 1'b1;
        job_base  <= JOB_BASE[j];
        job_cols  <= axi_wr_pkg::blk_cnt_t'(JOB_COLS[j]);
        job_rows  <= axi_wr_pkg::blk_cnt_t'(JOB_ROWS[j]);
        do
            @(posedge clk);
        while (!job_ready);
        job_valid <= 1'b0;

        if (hold_w)
        begin
            repeat (64) @(posedge clk);
            @(negedge clk);
            check_true(aw_issued - w_bursts == `AXW_DESC_DEPTH + 1,
                       "AW bursts did not run ahead to a full queue while wready was low");
            check_true(!awvalid, "awvalid stayed high with the descriptor queue full");
            hold_w = 1'b0;
        end

        while (done_cnt == done_before)
            @(negedge clk);
    endtask

    initial
    begin : stimulus
        rst_n     = 1'b0;
        job_valid = 1'b0;
        job_base  = '0;
        job_cols  = '0;
        job_rows  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int j = 0; j < NJOBS; j++)
            run_job(j);

        repeat (20) @(posedge clk);
        @(negedge clk);
        check_true((exp_aw_addr.size() == 0) && (exp_w_data.size() == 0),
                   "Some expected bursts or beats never appeared");
        check_true((slv_aw_id.size() == 0) && (slv_b_id.size() == 0) && !bvalid,
                   "Some write responses were never taken");
        check_true(done_cnt == NJOBS, "Not every job ended with exactly one done");

        $display("Checks: %0d, errors: %0d, jobs done: %0d of %0d, cycles: %0d",
                 checks, errors, done_cnt, NJOBS, cycle_cnt);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // Run limit scales with the total beat count
    initial
    begin : watchdog
        int limit;
        limit = 50 * total_job_beats() + 2000;
        while (cycle_cnt < limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hw/axi_frame_writer.sv ====
/*
 * Frame write master top. Accepts a job of base address and picture
 * size, pulls beats from the upstream source and writes them over AXI
 * in INCR bursts. Ends each job with done and err on the same cycle.
 */

`timescale 1ns/10ps

module axi_frame_writer
(
    input  logic                 clk,
    input  logic                 rst_n,

    // Job request
    input  logic                 job_valid,
    output logic                 job_ready,
    input  axi_wr_pkg::addr_t    job_base,
    input  axi_wr_pkg::blk_cnt_t job_cols,
    input  axi_wr_pkg::blk_cnt_t job_rows,

    // Upstream beats
    input  logic                 src_valid,
    output logic                 src_ready,
    input  axi_wr_pkg::data_t    src_data,

    // AXI write address
    output axi_wr_pkg::axid_t    awid,
    output axi_wr_pkg::addr_t    awaddr,
    output axi_wr_pkg::len_t     awlen,
    output logic                 awvalid,
    input  logic                 awready,

    // AXI write data
    output axi_wr_pkg::data_t    wdata,
    output axi_wr_pkg::strb_t    wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,

    // AXI write response
    input  logic                 bvalid,
    input  axi_wr_pkg::axid_t    bid,
    input  logic [1:0]           bresp,
    output logic                 bready,

    // Job status
    output logic                 done,
    output logic                 err
);

    logic              aw_fire;
    axi_wr_pkg::axid_t aw_id;
    logic              aw_final;

    burst_if i_burst_if ();

    // ----------------------------------------
    // Decode, execute, result
    // ----------------------------------------
    wr_burst_planner i_wr_burst_planner
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job_base  (job_base),
        .job_cols  (job_cols),
        .job_rows  (job_rows),
        .job_done  (done),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awvalid   (awvalid),
        .awready   (awready),
        .desc      (i_burst_if.planner),
        .aw_fire   (aw_fire),
        .aw_id     (aw_id),
        .aw_final  (aw_final)
    );

    wr_beat_streamer i_wr_beat_streamer
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .desc      (i_burst_if.streamer),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_data  (src_data),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready)
    );

    wr_resp_tracker i_wr_resp_tracker
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_fire  (aw_fire),
        .aw_id    (aw_id),
        .aw_final (aw_final),
        .bvalid   (bvalid),
        .bid      (bid),
        .bresp    (bresp),
        .bready   (bready),
        .done     (done),
        .err      (err)
    );

endmodule

// ==== hw/axi_wr_config.svh ====
/*
 * Build-time sizes for the AXI frame write master.
 * Included by the package and by any RTL file that needs a raw size.
 * Change values here only. Every stage picks them up at compile time.
 */

`ifndef AXI_WR_CONFIG_SVH
`define AXI_WR_CONFIG_SVH

// Bus widths
`define AXW_ADDR_W        32
`define AXW_DATA_W        64
`define AXW_ID_W          4

// Picture layout, data beats per encoded block
`define AXW_BEATS_PER_BLK 4

// Burst shaping
`define AXW_MAX_BURST     16

// Bursts the address channel may run ahead of data
`define AXW_DESC_DEPTH    4

`endif

// ==== hw/axi_wr_pkg.sv ====
/*
 * Shared types for the frame write master and its testbench.
 * Refer to them by scoped name, e.g. axi_wr_pkg::addr_t.
 */

`include "axi_wr_config.svh"

package axi_wr_pkg;

    // ----------------------------------------
    // Widths with a meaning
    // ----------------------------------------
    typedef logic [`AXW_ADDR_W-1:0]     addr_t;
    typedef logic [`AXW_DATA_W-1:0]     data_t;
    typedef logic [`AXW_DATA_W/8-1:0]   strb_t;
    typedef logic [`AXW_ID_W-1:0]       axid_t;
    typedef logic [9:0]                 blk_cnt_t;
    typedef logic [23:0]                beat_cnt_t;
    // AXI encoding, beats minus one
    typedef logic [7:0]                 len_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_Q
    } plan_state_e;

endpackage

// ==== hw/burst_if.sv ====
/*
 * Burst descriptor link from the address stage to the data stage.
 * One descriptor per AXI burst; moves when valid and ready are both high.
 */

`timescale 1ns/10ps

interface burst_if;

    logic                  desc_valid;
    logic                  desc_ready;
    axi_wr_pkg::len_t      desc_len;
    axi_wr_pkg::axid_t     desc_id;
    // Last burst of the job
    logic                  desc_final;

    modport planner
    (
        output desc_valid,
        input  desc_ready,
        output desc_len,
        output desc_id,
        output desc_final
    );

    modport streamer
    (
        input  desc_valid,
        output desc_ready,
        input  desc_len,
        input  desc_id,
        input  desc_final
    );

endinterface

// ==== hw/wr_beat_streamer.sv ====
/*
 * Execute stage. Takes one burst descriptor at a time and moves that
 * many beats from the upstream source onto the W channel, raising wlast
 * on the burst's final beat. Source and W handshakes are joined, so a
 * stalled wready holds the source.
 */

`timescale 1ns/10ps

module wr_beat_streamer
(
    input  logic              clk,
    input  logic              rst_n,
    burst_if.streamer         desc,
    input  logic              src_valid,
    output logic              src_ready,
    input  axi_wr_pkg::data_t src_data,
    output axi_wr_pkg::data_t wdata,
    output axi_wr_pkg::strb_t wstrb,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready
);

    logic               active;
    axi_wr_pkg::len_t   cur_len;
    axi_wr_pkg::len_t   beat_cnt;
    logic               w_fire;
    logic               desc_fire;

    // ----------------------------------------
    // Descriptor intake
    // ----------------------------------------
    // Free again on the last beat, so bursts can go back to back
    assign desc.desc_ready = !active || (w_fire && wlast);
    assign desc_fire       = desc.desc_valid && desc.desc_ready;

    // ----------------------------------------
    // Joined source and W handshake
    // ----------------------------------------
    assign wvalid    = active && src_valid;
    assign src_ready = active && wready;
    assign wdata     = src_data;
    // Full-width transfers only
    assign wstrb     = '1;
    assign wlast     = active && (beat_cnt == cur_len);
    assign w_fire    = wvalid && wready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            if (desc_fire)
            begin
                active   <= 1'b1;
                beat_cnt <= '0;
            end
            else if (w_fire)
            begin
                if (wlast)
                    active <= 1'b0;
                else
                    beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Burst length of the active descriptor
    always_ff @(posedge clk)
    begin
        if (desc_fire)
            cur_len <= desc.desc_len;
    end

endmodule

// ==== hw/wr_burst_planner.sv ====
/*
 * Decode stage. Takes a job, sizes it in beats and cuts it into INCR
 * bursts on the AW channel. Each issued burst is queued as a descriptor
 * for the data stage, so addresses can run a few bursts ahead of data.
 */

`timescale 1ns/10ps
`include "axi_wr_config.svh"

module wr_burst_planner
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 job_valid,
    output logic                 job_ready,
    input  axi_wr_pkg::addr_t    job_base,
    input  axi_wr_pkg::blk_cnt_t job_cols,
    input  axi_wr_pkg::blk_cnt_t job_rows,
    input  logic                 job_done,
    output axi_wr_pkg::axid_t    awid,
    output axi_wr_pkg::addr_t    awaddr,
    output axi_wr_pkg::len_t     awlen,
    output logic                 awvalid,
    input  logic                 awready,
    burst_if.planner             desc,
    output logic                 aw_fire,
    output axi_wr_pkg::axid_t    aw_id,
    output logic                 aw_final
);

    localparam int QW = $clog2(`AXW_DESC_DEPTH);
    localparam int CW = $clog2(`AXW_DESC_DEPTH + 1);
    localparam axi_wr_pkg::beat_cnt_t MAX_BEATS = axi_wr_pkg::beat_cnt_t'(`AXW_MAX_BURST);
    localparam axi_wr_pkg::addr_t STRIDE =
        axi_wr_pkg::addr_t'(`AXW_MAX_BURST * (`AXW_DATA_W / 8));

    axi_wr_pkg::plan_state_e state;
    logic                    job_fire;
    logic                    job_open;
    axi_wr_pkg::beat_cnt_t   job_beats;
    axi_wr_pkg::beat_cnt_t   rem_beats;
    axi_wr_pkg::beat_cnt_t   cur_beats;
    logic                    is_final;
    axi_wr_pkg::addr_t       next_addr;
    axi_wr_pkg::axid_t       id_cnt;

    axi_wr_pkg::len_t        q_len   [`AXW_DESC_DEPTH];
    axi_wr_pkg::axid_t       q_id    [`AXW_DESC_DEPTH];
    logic                    q_final [`AXW_DESC_DEPTH];
    logic [QW-1:0]           wr_ptr;
    logic [QW-1:0]           rd_ptr;
    logic [CW-1:0]           q_cnt;
    logic [CW-1:0]           q_cnt_next;
    logic                    q_pop;

    // ----------------------------------------
    // Job sizing and burst slicing
    // ----------------------------------------
    assign job_ready = (state == axi_wr_pkg::IDLE) && !job_open;
    assign job_fire  = job_valid && job_ready;
    assign job_beats = axi_wr_pkg::beat_cnt_t'(job_cols) * axi_wr_pkg::beat_cnt_t'(job_rows)
                     * axi_wr_pkg::beat_cnt_t'(`AXW_BEATS_PER_BLK);

    assign is_final  = (rem_beats <= MAX_BEATS);
    assign cur_beats = is_final ? rem_beats : MAX_BEATS;

    assign awvalid   = (state == axi_wr_pkg::ISSUE);
    assign awaddr    = next_addr;
    assign awlen     = axi_wr_pkg::len_t'(cur_beats - 1'b1);
    assign awid      = id_cnt;
    assign aw_fire   = awvalid && awready;
    assign aw_id     = id_cnt;
    // Without aw_fire this flags an empty job to the tracker
    assign aw_final  = aw_fire ? is_final : (job_fire && (job_beats == '0));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= axi_wr_pkg::IDLE;
            job_open  <= 1'b0;
            rem_beats <= '0;
            id_cnt    <= '0;
        end
        else
        begin
            if (job_fire)
                job_open <= 1'b1;
            else if (job_done)
                job_open <= 1'b0;

            case (state)
                axi_wr_pkg::IDLE:
                begin
                    if (job_fire)
                    begin
                        rem_beats <= job_beats;
                        if (job_beats != '0)
                            state <= axi_wr_pkg::ISSUE;
                    end
                end
                axi_wr_pkg::ISSUE:
                begin
                    if (aw_fire)
                    begin
                        rem_beats <= rem_beats - cur_beats;
                        id_cnt    <= id_cnt + 1'b1;
                        if (is_final)
                            state <= axi_wr_pkg::IDLE;
                        else if (q_cnt_next == CW'(`AXW_DESC_DEPTH))
                            state <= axi_wr_pkg::WAIT_Q;
                    end
                end
                axi_wr_pkg::WAIT_Q:
                begin
                    // Resume once the data stage frees a slot
                    if (q_cnt_next != CW'(`AXW_DESC_DEPTH))
                        state <= axi_wr_pkg::ISSUE;
                end
                default:
                    state <= axi_wr_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (job_fire)
            next_addr <= job_base;
        else if (aw_fire)
            next_addr <= next_addr + STRIDE;
    end

    // ----------------------------------------
    // Descriptor queue
    // ----------------------------------------
    assign q_pop           = desc.desc_valid && desc.desc_ready;
    assign q_cnt_next      = q_cnt + CW'(aw_fire) - CW'(q_pop);
    assign desc.desc_valid = (q_cnt != '0);
    assign desc.desc_len   = q_len[rd_ptr];
    assign desc.desc_id    = q_id[rd_ptr];
    assign desc.desc_final = q_final[rd_ptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end
        else
        begin
            q_cnt <= q_cnt_next;
            if (aw_fire)
                wr_ptr <= (wr_ptr == QW'(`AXW_DESC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (q_pop)
                rd_ptr <= (rd_ptr == QW'(`AXW_DESC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_fire)
        begin
            q_len[wr_ptr]   <= awlen;
            q_id[wr_ptr]    <= id_cnt;
            q_final[wr_ptr] <= is_final;
        end
    end

endmodule

// ==== hw/wr_resp_tracker.sv ====
/*
 * Result stage. Counts bursts in flight, checks every B response for an
 * OKAY code and the expected in-order ID, and ends the job with a done
 * pulse that carries the job's error flag.
 */

`timescale 1ns/10ps

module wr_resp_tracker
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              aw_fire,
    input  axi_wr_pkg::axid_t aw_id,
    input  logic              aw_final,
    input  logic              bvalid,
    input  axi_wr_pkg::axid_t bid,
    input  logic [1:0]        bresp,
    output logic              bready,
    output logic              done,
    output logic              err
);

    axi_wr_pkg::beat_cnt_t out_cnt;
    axi_wr_pkg::axid_t     exp_id;
    logic                  final_issued;
    logic                  job_err;
    logic                  b_fire;
    logic                  bad_resp;
    logic                  final_hit;
    logic                  empty_job;

    assign bready    = (out_cnt != '0);
    assign b_fire    = bvalid && bready;
    assign bad_resp  = (bresp != 2'(axi_wr_pkg::OKAY)) || (bid != exp_id);
    // Responses come back in order, so the last one in flight is the final one
    assign final_hit = b_fire && final_issued && (out_cnt == 24'd1);
    assign empty_job = aw_final && !aw_fire;

    // ----------------------------------------
    // In-flight accounting
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_cnt      <= '0;
            exp_id       <= '0;
            final_issued <= 1'b0;
        end
        else
        begin
            out_cnt <= out_cnt + 24'(aw_fire) - 24'(b_fire);
            // Resync to the issued ID whenever nothing is in flight
            if (aw_fire && (out_cnt == '0))
                exp_id <= aw_id;
            else if (b_fire)
                exp_id <= exp_id + 1'b1;

            if (aw_fire && aw_final)
                final_issued <= 1'b1;
            else if (final_hit)
                final_issued <= 1'b0;
        end
    end

    // ----------------------------------------
    // Job status
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            job_err <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
        end
        else
        begin
            if (final_hit)
                job_err <= 1'b0;
            else if (b_fire && bad_resp)
                job_err <= 1'b1;

            done <= final_hit || empty_job;
            err  <= final_hit && (job_err || bad_resp);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/bash
# Build and run the frame writer testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_frame_writer \
    -f vlog.f -o tb_axi_frame_writer

./obj_dir/tb_axi_frame_writer | tee sim.log

# The testbench reports its verdict in the log
if grep -q "Simulation failed" sim.log
then
    echo "run.sh: testbench reported a failure"
    exit 1
fi

echo "run.sh: testbench finished clean"

// ==== vlog.f ====
+incdir+hw
hw/axi_wr_pkg.sv
hw/burst_if.sv
hw/wr_burst_planner.sv
hw/wr_beat_streamer.sv
hw/wr_resp_tracker.sv
hw/axi_frame_writer.sv
dv/tb_axi_frame_writer.sv
